// File: source/isaPkg.sv
package isaPkg;

    localparam int xlen = 32;

    typedef logic [4:0] regAddrT;
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] funcT;

    // major opcodes
    localparam opcodeT opRType = 6'h00;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opSlti  = 6'h0a;
    localparam opcodeT opSltiu = 6'h0b;
    localparam opcodeT opAndi  = 6'h0c;
    localparam opcodeT opOri   = 6'h0d;
    localparam opcodeT opXori  = 6'h0e;
    localparam opcodeT opLui   = 6'h0f;

    // R-type function codes
    localparam funcT fnSll   = 6'h00;
    localparam funcT fnSrl   = 6'h02;
    localparam funcT fnSra   = 6'h03;
    localparam funcT fnSllv  = 6'h04;
    localparam funcT fnSrlv  = 6'h06;
    localparam funcT fnSrav  = 6'h07;
    localparam funcT fnMfhi  = 6'h10;
    localparam funcT fnMthi  = 6'h11;
    localparam funcT fnMflo  = 6'h12;
    localparam funcT fnMtlo  = 6'h13;
    localparam funcT fnMult  = 6'h18;
    localparam funcT fnMultu = 6'h19;
    localparam funcT fnAdd   = 6'h20;
    localparam funcT fnAddu  = 6'h21;
    localparam funcT fnSub   = 6'h22;
    localparam funcT fnSubu  = 6'h23;
    localparam funcT fnAnd   = 6'h24;
    localparam funcT fnOr    = 6'h25;
    localparam funcT fnXor   = 6'h26;
    localparam funcT fnNor   = 6'h27;
    localparam funcT fnSlt   = 6'h2a;
    localparam funcT fnSltu  = 6'h2b;

    // low bit of each instruction field
    localparam int opcodeLsb = 26;   // 31:26
    localparam int rsLsb     = 21;   // 25:21
    localparam int rtLsb     = 16;   // 20:16
    localparam int rdLsb     = 11;   // 15:11
    localparam int shamtLsb  = 6;    // 10:6
    localparam int funcLsb   = 0;    // 5:0
    localparam int immLsb    = 0;    // 15:0

endpackage

// File: source/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt,
        aluSltu, aluSll, aluSrl, aluSra, aluLui, aluPass
    } aluOpT;

    typedef enum logic [2:0] {
        hlNone, hlMult, hlMultu, hlMfhi, hlMflo, hlMthi, hlMtlo
    } hiLoOpT;

    typedef struct packed {
        aluOpT  aluOp;
        hiLoOpT hiLoOp;
        logic   aluSrc;     // immediate as operand B
        logic   immSigned;
        logic   shiftVar;   // shift amount from rs
        logic   regDst;     // rd, else rt
        logic   regWrite;
        logic   illegal;
    } ctrlT;

    typedef struct packed {
        ctrlT             ctrl;
        logic [31:0]      opA;
        logic [31:0]      opB;
        logic [4:0]       shamt;
        isaPkg::regAddrT  dest;
    } execReqT;

    // also the core's output record
    typedef struct packed {
        isaPkg::regAddrT  dest;
        logic [31:0]      value;
    } wbResultT;

endpackage

// File: source/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [31:0]   inst,
    output ctrlPkg::ctrlT ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    opcodeT op;
    funcT   fn;

    assign op = inst[opcodeLsb +: 6];
    assign fn = inst[funcLsb +: 6];

    always_comb
        begin
            ctrl = '0;
            case (op)
                opRType:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        case (fn)
                            fnAdd, fnAddu: ctrl.aluOp = aluAdd;   // no overflow trap
                            fnSub, fnSubu: ctrl.aluOp = aluSub;
                            fnAnd:  ctrl.aluOp = aluAnd;
                            fnOr:   ctrl.aluOp = aluOr;
                            fnXor:  ctrl.aluOp = aluXor;
                            fnNor:  ctrl.aluOp = aluNor;
                            fnSlt:  ctrl.aluOp = aluSlt;
                            fnSltu: ctrl.aluOp = aluSltu;
                            fnSll:  ctrl.aluOp = aluSll;
                            fnSrl:  ctrl.aluOp = aluSrl;
                            fnSra:  ctrl.aluOp = aluSra;
                            fnSllv, fnSrlv, fnSrav:
                                begin
                                    ctrl.shiftVar = 1'b1;
                                    if (fn == fnSllv)
                                        ctrl.aluOp = aluSll;
                                    else if (fn == fnSrlv)
                                        ctrl.aluOp = aluSrl;
                                    else
                                        ctrl.aluOp = aluSra;
                                end
                            fnMfhi, fnMflo:
                                begin
                                    ctrl.aluOp  = aluPass;
                                    ctrl.hiLoOp = (fn == fnMfhi) ? hlMfhi : hlMflo;
                                end
                            fnMthi, fnMtlo, fnMult, fnMultu:
                                begin
                                    ctrl.aluOp    = aluPass;
                                    ctrl.regWrite = 1'b0;   // HI/LO only
                                    case (fn)
                                        fnMthi:  ctrl.hiLoOp = hlMthi;
                                        fnMtlo:  ctrl.hiLoOp = hlMtlo;
                                        fnMult:  ctrl.hiLoOp = hlMult;
                                        default: ctrl.hiLoOp = hlMultu;
                                    endcase
                                end
                            default:
                                begin
                                    ctrl         = '0;
                                    ctrl.illegal = 1'b1;
                                end
                        endcase
                    end

                opAddi, opAddiu, opSlti, opSltiu:
                    begin
                        ctrl.aluSrc    = 1'b1;
                        ctrl.immSigned = 1'b1;   // sltiu compares a sign-extended imm too
                        ctrl.regWrite  = 1'b1;
                        if (op == opSlti)
                            ctrl.aluOp = aluSlt;
                        else if (op == opSltiu)
                            ctrl.aluOp = aluSltu;
                        else
                            ctrl.aluOp = aluAdd;
                    end

                opAndi, opOri, opXori, opLui:
                    begin
                        ctrl.aluSrc   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        case (op)
                            opAndi:  ctrl.aluOp = aluAnd;
                            opOri:   ctrl.aluOp = aluOr;
                            opXori:  ctrl.aluOp = aluXor;
                            default: ctrl.aluOp = aluLui;
                        endcase
                    end

                default:
                    ctrl.illegal = 1'b1;
            endcase
        end

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                      clk,
    input  logic                      rstN,
    input  isaPkg::regAddrT           rdAddrA,
    input  isaPkg::regAddrT           rdAddrB,
    output logic [isaPkg::xlen-1:0]   rdDataA,
    output logic [isaPkg::xlen-1:0]   rdDataB,
    input  logic                      wrEn,
    input  isaPkg::regAddrT           wrAddr,
    input  logic [isaPkg::xlen-1:0]   wrData
);
    import isaPkg::*;

    logic [xlen-1:0] regs [32];

    // all registers come up zero
    always_ff @(posedge clk or negedge rstN)
        begin
            if (!rstN)
                begin
                    for (int i = 0; i < 32; i++)
                        regs[i] <= '0;
                end
            else if (wrEn && wrAddr != '0)
                regs[wrAddr] <= wrData;
        end

    // r0 reads zero regardless of contents
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: source/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    // accept when empty or draining this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rstN)
        begin
            if (!rstN)
                outValid <= 1'b0;
            else if (inReady)
                outValid <= inValid;
        end

    always_ff @(posedge clk)
        begin
            if (inValid && inReady)
                outData <= inData;
        end

endmodule

// File: source/issueLogic.sv
`timescale 1ns/1ps

module issueLogic (
    input  logic                      instValid,
    output logic                      instReady,
    input  logic [31:0]               inst,
    output isaPkg::regAddrT           rdAddrA,
    output isaPkg::regAddrT           rdAddrB,
    input  logic [isaPkg::xlen-1:0]   rdDataA,
    input  logic [isaPkg::xlen-1:0]   rdDataB,
    input  logic                      busyValid,
    input  isaPkg::regAddrT           busyDest,
    output logic                      reqValid,
    input  logic                      reqReady,
    output ctrlPkg::execReqT          req
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlT            ctrl;
    regAddrT         rs;
    regAddrT         rt;
    regAddrT         rd;
    logic [15:0]     imm;
    logic [xlen-1:0] immExt;
    logic            hazard;

    decoder dec (
        .inst (inst),
        .ctrl (ctrl)
    );

    assign rs  = inst[rsLsb +: 5];
    assign rt  = inst[rtLsb +: 5];
    assign rd  = inst[rdLsb +: 5];
    assign imm = inst[immLsb +: 16];

    assign rdAddrA = rs;
    assign rdAddrB = rt;

    assign immExt = ctrl.immSigned ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    // rt is only a source when no immediate is used
    assign hazard = busyValid && busyDest != '0 && !ctrl.illegal &&
                    (busyDest == rs || (!ctrl.aluSrc && busyDest == rt));

    assign instReady = reqReady && !hazard;
    assign reqValid  = instValid && !hazard && !ctrl.illegal;   // illegal words retire here

    assign req.ctrl  = ctrl;
    assign req.opA   = rdDataA;
    assign req.opB   = ctrl.aluSrc ? immExt : rdDataB;
    assign req.shamt = inst[shamtLsb +: 5];
    assign req.dest  = ctrl.regDst ? rd : rt;

endmodule

// File: source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  ctrlPkg::execReqT          req,
    output logic [isaPkg::xlen-1:0]   result
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [4:0] shAmt;
    logic       ltSigned;
    logic       ltUnsigned;

    // variable shifts take the amount from rs
    assign shAmt = req.ctrl.shiftVar ? req.opA[4:0] : req.shamt;

    assign ltSigned   = $signed(req.opA) < $signed(req.opB);
    assign ltUnsigned = req.opA < req.opB;

    always_comb
        begin
            case (req.ctrl.aluOp)
                aluAdd:  result = req.opA + req.opB;
                aluSub:  result = req.opA - req.opB;
                aluAnd:  result = req.opA & req.opB;
                aluOr:   result = req.opA | req.opB;
                aluXor:  result = req.opA ^ req.opB;
                aluNor:  result = ~(req.opA | req.opB);
                aluSlt:  result = {{(xlen-1){1'b0}}, ltSigned};
                aluSltu: result = {{(xlen-1){1'b0}}, ltUnsigned};
                aluSll:  result = req.opB << shAmt;
                aluSrl:  result = req.opB >> shAmt;
                aluSra:  result = $signed(req.opB) >>> shAmt;
                aluLui:  result = {req.opB[15:0], 16'h0000};   // imm into upper half
                aluPass: result = req.opA;
                default: result = '0;
            endcase
        end

endmodule

// File: source/hiLoUnit.sv
`timescale 1ns/1ps

module hiLoUnit (
    input  logic                      clk,
    input  logic                      rstN,
    input  ctrlPkg::execReqT          req,
    input  logic                      commit,
    output logic [isaPkg::xlen-1:0]   result
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic        [xlen-1:0]   hi;
    logic        [xlen-1:0]   lo;
    logic signed [2*xlen-1:0] prodSigned;
    logic        [2*xlen-1:0] prodUnsigned;

    assign prodSigned   = $signed(req.opA) * $signed(req.opB);
    assign prodUnsigned = {32'h0, req.opA} * {32'h0, req.opB};

    // written only on the execute to writeback handoff
    always_ff @(posedge clk or negedge rstN)
        begin
            if (!rstN)
                begin
                    hi <= '0;
                    lo <= '0;
                end
            else if (commit)
                begin
                    case (req.ctrl.hiLoOp)
                        hlMult:  {hi, lo} <= prodSigned;
                        hlMultu: {hi, lo} <= prodUnsigned;
                        hlMthi:  hi <= req.opA;
                        hlMtlo:  lo <= req.opA;
                        default: ;
                    endcase
                end
        end

    always_comb
        begin
            case (req.ctrl.hiLoOp)
                hlMfhi:  result = hi;
                hlMflo:  result = lo;
                default: result = '0;
            endcase
        end

endmodule

// File: source/execCore.sv
`timescale 1ns/1ps

module execCore (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instValid,
    output logic              instReady,
    input  logic [31:0]       inst,
    output logic              resValid,
    input  logic              resReady,
    output ctrlPkg::wbResultT res
);
    import isaPkg::*;
    import ctrlPkg::*;

    regAddrT         rdAddrA;
    regAddrT         rdAddrB;
    logic [xlen-1:0] rdDataA;
    logic [xlen-1:0] rdDataB;
    logic            busyValid;
    regAddrT         busyDest;
    logic            reqValid;
    logic            reqReady;
    execReqT         req;
    logic            exValid;
    logic            exReady;
    execReqT         exReq;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] hiLoResult;
    logic            handoff;
    logic            rfWrEn;
    logic            wbInValid;
    logic            wbInReady;
    wbResultT        wbIn;

    assign busyValid = exValid && exReq.ctrl.regWrite;
    assign busyDest  = busyValid ? exReq.dest : '0;

    // entries without regWrite leave execute without waiting on writeback
    assign exReady   = wbInReady || !exReq.ctrl.regWrite;
    assign handoff   = exValid && exReady;
    assign wbInValid = exValid && exReq.ctrl.regWrite;
    assign rfWrEn    = handoff && exReq.ctrl.regWrite && exReq.dest != '0;

    assign wbIn = '{dest:  exReq.dest,
                    value: (exReq.ctrl.hiLoOp inside {hlMfhi, hlMflo}) ? hiLoResult : aluResult};

    issueLogic issue (
        .instValid (instValid),
        .instReady (instReady),
        .inst      (inst),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .busyValid (busyValid),
        .busyDest  (busyDest),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .req       (req)
    );

    regFile regs (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (rfWrEn),
        .wrAddr  (exReq.dest),
        .wrData  (wbIn.value)
    );

    stageReg #(.payloadT(execReqT)) execStage (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (reqValid),
        .inReady  (reqReady),
        .inData   (req),
        .outValid (exValid),
        .outReady (exReady),
        .outData  (exReq)
    );

    aluUnit alu (
        .req    (exReq),
        .result (aluResult)
    );

    hiLoUnit hiLo (
        .clk    (clk),
        .rstN   (rstN),
        .req    (exReq),
        .commit (handoff),
        .result (hiLoResult)
    );

    stageReg #(.payloadT(wbResultT)) wbStage (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (wbInValid),
        .inReady  (wbInReady),
        .inData   (wbIn),
        .outValid (resValid),
        .outReady (resReady),
        .outData  (res)
    );

endmodule

// File: test/execCore_properties.sv
`timescale 1ns/1ps

module execCore_properties (
    input logic               clk,
    input logic               rstN,
    input logic               resValid,
    input logic               resReady,
    input ctrlPkg::wbResultT  res,
    input logic [31:0]        r0
);

    // a stalled record keeps its value
    resHeld: assert property (@(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid && $stable(res))
        else $error("res changed while resValid was high and resReady low");

    resQuietInReset: assert property (@(posedge clk) !rstN |-> !resValid)
        else $error("resValid high during reset");

    // writes aimed at r0 never reach its storage
    noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
        r0 == '0)
        else $error("register 0 storage was written");

endmodule

bind execCore execCore_properties props (
    .clk      (clk),
    .rstN     (rstN),
    .resValid (resValid),
    .resReady (resReady),
    .res      (res),
    .r0       (regs.regs[0])
);

// File: test/execCore_tb.sv
`timescale 1ns/1ps

module execCore_tb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int numRandom   = 3000;
    localparam int numDirected = 21;

    logic        clk;
    logic        rstN;
    logic        instValid;
    logic        instReady;
    logic [31:0] inst;
    logic        resValid;
    logic        resReady;
    wbResultT    res;

    integer      seed;
    logic [31:0] mRegs [32];   // reference register file
    logic [31:0] mHi;
    logic [31:0] mLo;
    wbResultT    expQ [$];
    wbResultT    expRec;

    funcT rFuncs [22] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt,
                          fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnMult,
                          fnMultu, fnMfhi, fnMflo, fnMthi, fnMtlo};
    opcodeT iOps [8] = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};

    execCore execCore_i (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instReady (instReady),
        .inst      (inst),
        .resValid  (resValid),
        .resReady  (resReady),
        .res       (res)
    );

    always #10 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual)
            begin
                $display("Fail %s expected %h actual %h", name, expected, actual);
                failRun("value mismatch");
            end
    endtask

    function automatic logic [31:0] nextRandom();
        return $random(seed);
    endfunction

    function automatic logic [31:0] rType(funcT fn, regAddrT rs, regAddrT rt, regAddrT rd,
                                          logic [4:0] sh);
        return {opRType, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(opcodeT op, regAddrT rs, regAddrT rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] randomInst();
        logic [31:0] pick;
        logic [31:0] fields;
        logic [31:0] word;
        logic [4:0]  k;
        pick   = nextRandom() % 100;
        fields = nextRandom();
        word   = nextRandom();
        k      = 5'(word % 22);
        if (pick < 10)
            return word;   // mostly illegal, sometimes not
        else if (pick < 60)
            return rType(rFuncs[k], {2'b00, fields[2:0]}, {2'b00, fields[5:3]},
                         {2'b00, fields[8:6]}, fields[13:9]);
        else
            return iType(iOps[fields[26:24]], {2'b00, fields[2:0]}, {2'b00, fields[5:3]},
                         word[31:16]);
    endfunction

    // program order update at acceptance
    task automatic modelAccept(input logic [31:0] w);
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     sImm;
        logic [31:0]     zImm;
        logic [31:0]     value;
        logic [4:0]      sh;
        regAddrT         dest;
        logic            writes;
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        a      = mRegs[w[25:21]];
        b      = mRegs[w[20:16]];
        sImm   = {{16{w[15]}}, w[15:0]};
        zImm   = {16'h0000, w[15:0]};
        sh     = w[10:6];
        sa     = longint'($signed(a));
        sb     = longint'($signed(b));
        ua     = 64'(a);
        ub     = 64'(b);
        dest   = w[20:16];
        value  = '0;
        writes = 1'b1;
        case (w[31:26])
            opRType:
                begin
                    dest = w[15:11];
                    case (w[5:0])
                        fnAdd, fnAddu: value = a + b;
                        fnSub, fnSubu: value = a - b;
                        fnAnd:  value = a & b;
                        fnOr:   value = a | b;
                        fnXor:  value = a ^ b;
                        fnNor:  value = ~(a | b);
                        fnSlt:  value = {31'h0, $signed(a) < $signed(b)};
                        fnSltu: value = {31'h0, a < b};
                        fnSll:  value = b << sh;
                        fnSrl:  value = b >> sh;
                        fnSra:  value = $signed(b) >>> sh;
                        fnSllv: value = b << a[4:0];
                        fnSrlv: value = b >> a[4:0];
                        fnSrav: value = $signed(b) >>> a[4:0];
                        fnMfhi: value = mHi;
                        fnMflo: value = mLo;
                        default:
                            begin
                                writes = 1'b0;   // HI/LO writers and unknown codes
                                case (w[5:0])
                                    fnMult:  {mHi, mLo} = sa * sb;
                                    fnMultu: {mHi, mLo} = ua * ub;
                                    fnMthi:  mHi = a;
                                    fnMtlo:  mLo = a;
                                    default: ;
                                endcase
                            end
                    endcase
                end
            opAddi, opAddiu: value = a + sImm;
            opSlti:  value = {31'h0, $signed(a) < $signed(sImm)};
            opSltiu: value = {31'h0, a < sImm};
            opAndi:  value = a & zImm;
            opOri:   value = a | zImm;
            opXori:  value = a ^ zImm;
            opLui:   value = {w[15:0], 16'h0000};
            default: writes = 1'b0;
        endcase
        if (writes)
            begin
                expQ.push_back(wbResultT'{dest: dest, value: value});
                if (dest != '0)
                    mRegs[dest] = value;   // r0 keeps zero
            end
    endtask

    // handshake is decided mid cycle, where inputs and ready are settled
    task automatic sendInst(input logic [31:0] word);
        logic taken;
        inst      = word;
        instValid = 1'b1;
        taken     = 1'b0;
        while (!taken)
            begin
                @(negedge clk);
                taken = instReady;
                if (taken)
                    modelAccept(word);
                @(posedge clk);
                #1;
                resReady = (nextRandom() % 10) >= 3;
            end
        instValid = 1'b0;
    endtask

    always @(negedge clk)
        begin
            if (rstN && resValid && resReady)
                begin
                    if (expQ.size() == 0)
                        failRun("output record appeared with nothing expected");
                    else
                        begin
                            expRec = expQ.pop_front();
                            checkValue("wb record", 64'(expRec), 64'(res));
                        end
                end
        end

    initial
        begin
            #((numRandom + numDirected) * 20 * 20);
            failRun("watchdog timeout, the run did not finish in time");
        end

    initial
        begin
            seed      = 32'hc751;
            clk       = 1'b0;
            rstN      = 1'b0;
            instValid = 1'b0;
            inst      = '0;
            resReady  = 1'b1;
            mHi       = '0;
            mLo       = '0;
            for (int i = 0; i < 32; i++)
                mRegs[i] = '0;
            repeat (2) @(posedge clk);
            @(negedge clk);
            checkValue("resValid in reset", 64'(1'b0), 64'(resValid));
            repeat (2) @(posedge clk);
            #1 rstN = 1'b1;
            @(negedge clk);
            checkValue("instReady after reset", 64'(1'b1), 64'(instReady));
            @(posedge clk);
            #1;

            // HI, LO and registers start at zero
            sendInst(rType(fnMfhi, 5'd0, 5'd0, 5'd1, 5'd0));
            sendInst(rType(fnMflo, 5'd0, 5'd0, 5'd2, 5'd0));
            sendInst(rType(fnAddu, 5'd3, 5'd4, 5'd5, 5'd0));
            // immediate extension, dependent chain
            sendInst(iType(opAddiu, 5'd0, 5'd1, 16'hfffb));
            sendInst(iType(opLui, 5'd0, 5'd2, 16'h8123));
            sendInst(iType(opOri, 5'd2, 5'd2, 16'hf00d));
            sendInst(iType(opSltiu, 5'd1, 5'd3, 16'hffff));
            sendInst(iType(opAndi, 5'd1, 5'd4, 16'h8fff));
            sendInst(rType(fnMult, 5'd1, 5'd2, 5'd0, 5'd0));
            sendInst(rType(fnMfhi, 5'd0, 5'd0, 5'd5, 5'd0));
            sendInst(rType(fnMflo, 5'd0, 5'd0, 5'd6, 5'd0));
            sendInst(rType(fnMultu, 5'd1, 5'd2, 5'd0, 5'd0));
            sendInst(rType(fnMfhi, 5'd0, 5'd0, 5'd5, 5'd0));
            sendInst(rType(fnMflo, 5'd0, 5'd0, 5'd6, 5'd0));
            sendInst(rType(fnMthi, 5'd6, 5'd0, 5'd0, 5'd0));
            sendInst(rType(fnMtlo, 5'd5, 5'd0, 5'd0, 5'd0));
            sendInst(rType(fnMfhi, 5'd0, 5'd0, 5'd7, 5'd0));
            sendInst(rType(fnMflo, 5'd0, 5'd0, 5'd7, 5'd0));
            sendInst(32'hfc00_0000);   // unknown opcode
            sendInst(iType(opAddiu, 5'd0, 5'd0, 16'h0055));
            sendInst(rType(fnOr, 5'd0, 5'd1, 5'd3, 5'd0));

            for (int n = 0; n < numRandom; n++)
                sendInst(randomInst());

            // drain under back-pressure, then with the output open
            repeat (40)
                begin
                    @(posedge clk);
                    #1;
                    resReady = (nextRandom() % 10) >= 3;
                end
            resReady = 1'b1;
            repeat (10) @(posedge clk);
            if (expQ.size() != 0)
                failRun($sformatf("%0d expected records never appeared", expQ.size()));
            else
                begin
                    $display("** PASS **");
                    $finish;
                end
        end

endmodule

// File: compile.f
source/isaPkg.sv
source/ctrlPkg.sv
source/decoder.sv
source/regFile.sv
source/stageReg.sv
source/issueLogic.sv
source/aluUnit.sv
source/hiLoUnit.sv
source/execCore.sv
test/execCore_properties.sv
test/execCore_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= execCore_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
